//--- all.f
+incdir+verilog
verilog/pc_pkg.sv
verilog/l2_pkg.sv
verilog/core_arbiter.sv
verilog/l2_request_queue.sv
verilog/l2_memory.sv
verilog/performance_counters.sv
verilog/gpgpu_mem.sv
sim/gpgpu_mem_assert.sv
sim/gpgpu_mem_tb.sv

//--- sim/gpgpu_mem_tb.sv
// Testbench for the GPGPU memory side with two core drivers, reference model and response compare
`include "gpgpu_macros.svh"

module gpgpu_mem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam TOTAL_REQUESTS = 165;	// 17 + 40 + 20 + 4 + 80 + 4
	localparam TIMEOUT_CYCLES = TOTAL_REQUESTS * 8 + 200;

	logic clk;
	logic reset;
	l2_pkg::l2req_packet_t core0_req;
	l2_pkg::l2req_packet_t core1_req;
	logic core0_ready;
	logic core1_ready;
	l2_pkg::l2rsp_packet_t l2rsp_packet;
	logic halt0;
	logic halt1;
	logic processor_halt;

	l2_pkg::l2req_packet_t todo0[$];	// Core 0 packets not yet accepted
	l2_pkg::l2req_packet_t todo1[$];
	l2_pkg::l2req_packet_t expected[$];	// Stamped requests in acceptance order
	logic [31:0] model_mem[1 << `MEM_ADDR_BITS];
	logic [31:0] issue_counts[2];	// Acceptances up to last cycle
	logic [31:0] issue_snap[2];	// One cycle older as a counter read sees them
	logic [31:0] load_count;
	logic [31:0] store_count;
	logic last_core;
	logic [31:0] rand_state;
	int accept_count = 0;
	int response_count = 0;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;

	gpgpu_mem gpgpu_mem_i(.*);

	bind gpgpu_mem gpgpu_mem_assert gpgpu_mem_assert_i(.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic l2_pkg::l2req_packet_t make_request(input l2_pkg::l2_op_t op,
		input logic [31:0] index, input logic [31:0] data);
		l2_pkg::l2req_packet_t p;
		p = '0;	// Core field left at 0
		p.valid = 1'b1;
		p.op = op;
		if (op == l2_pkg::L2_PC_READ)
			p.address.pc.index = pc_pkg::pc_index_t'(index);
		else
			p.address.mem.index = index[`MEM_ADDR_BITS - 1:0];
		p.data = data;
		return p;
	endfunction

	// Expected response word from the model state
	function automatic logic [31:0] expected_data(input l2_pkg::l2req_packet_t req);
		logic [31:0] result;
		case (req.op)
			l2_pkg::L2_STORE: result = req.data;
			l2_pkg::L2_PC_READ:
			begin
				case (req.address.pc.index)
					2'd0: result = issue_snap[0];
					2'd1: result = issue_snap[1];
					2'd2: result = load_count;
					default: result = store_count;
				endcase
			end
			default: result = model_mem[req.address.mem.index];	// Zero if never written
		endcase
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		if (got !== want)
		begin
			value_errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic compare_response();
		l2_pkg::l2req_packet_t req;
		if (l2rsp_packet.valid)
		begin
			response_count++;
			if (expected.size() == 0)
			begin
				other_errors++;
				$display("Error at %0t: response arrived with no request outstanding", $time);
			end
			else
			begin
				req = expected.pop_front();
				check_value("l2rsp_packet.core", l2rsp_packet.core, req.core);
				check_value("l2rsp_packet.op", l2rsp_packet.op, req.op);
				check_value("l2rsp_packet.data", l2rsp_packet.data, expected_data(req));
				if (req.op == l2_pkg::L2_STORE)
				begin
					model_mem[req.address.mem.index] = req.data;
					store_count++;
				end
				if (req.op == l2_pkg::L2_LOAD)
					load_count++;
			end
		end
	endtask

	task automatic record_acceptances();
		l2_pkg::l2req_packet_t req;
		logic want0;
		logic want1;
		// Lone asker wins, two askers go to the core not granted last
		want0 = core0_req.valid && (!core1_req.valid || last_core);
		want1 = core1_req.valid && (!core0_req.valid || !last_core);
		if (core0_ready || core1_ready)
		begin
			check_value("core0_ready", core0_ready, want0);
			check_value("core1_ready", core1_ready, want1);
		end
		if (core0_req.valid && core0_ready)
		begin
			req = core0_req;
			req.core = 1'b0;
			expected.push_back(req);
			issue_counts[0]++;
			accept_count++;
			last_core = 1'b0;
		end
		if (core1_req.valid && core1_ready)
		begin
			req = core1_req;
			req.core = 1'b1;
			expected.push_back(req);
			issue_counts[1]++;
			accept_count++;
			last_core = 1'b1;
		end
	endtask

	// Mid-cycle sampling with responses before this cycle's acceptances
	always @(negedge clk)
	begin
		if (!reset)
		begin
			compare_response();
			issue_snap = issue_counts;
			record_acceptances();
		end
	end

	// Core 0 driver holds its packet until accepted
	initial
	begin
		core0_req = '0;
		forever
		begin
			@(negedge clk);
			if (core0_req.valid && core0_ready)
				void'(todo0.pop_front());
			@(posedge clk);
			#1;
			if (todo0.size() != 0)
				core0_req = todo0[0];
			else
				core0_req = '0;
		end
	end

	// Core 1 driver
	initial
	begin
		core1_req = '0;
		forever
		begin
			@(negedge clk);
			if (core1_req.valid && core1_ready)
				void'(todo1.pop_front());
			@(posedge clk);
			#1;
			if (todo1.size() != 0)
				core1_req = todo1[0];
			else
				core1_req = '0;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, %0d responses still missing", cycle_count,
				expected.size());
			$display("TEST FAIL");
			$finish;
		end
	end

	// Drained when nothing waits to send and nothing awaits a response
	task automatic wait_idle();
		while (todo0.size() != 0 || todo1.size() != 0 || expected.size() != 0 ||
			core0_req.valid || core1_req.valid)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	task automatic queue_random(input int n);
		l2_pkg::l2_op_t op;
		logic [31:0] index;
		for (int i = 0; i < 2 * n; i++)
		begin
			rand_state = xorshift(rand_state);
			case (rand_state % 3)
				0: op = l2_pkg::L2_LOAD;
				1: op = l2_pkg::L2_STORE;
				default: op = l2_pkg::L2_PC_READ;
			endcase
			index = rand_state >> 8;
			rand_state = xorshift(rand_state);
			if (i % 2 == 0)
				todo0.push_back(make_request(op, index, rand_state));
			else
				todo1.push_back(make_request(op, index, rand_state));
		end
	endtask

	initial
	begin
		reset = 1'b1;
		halt0 = 1'b0;
		halt1 = 1'b0;
		rand_state = 32'h83bb_fde3;
		last_core = 1'b1;	// Matches arbiter reset state
		load_count = '0;
		store_count = '0;
		issue_counts = '{default: '0};
		issue_snap = '{default: '0};
		foreach (model_mem[i])
			model_mem[i] = '0;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);

		// Stores then loads from one core plus a never-written word
		for (int i = 0; i < 8; i++)
			todo0.push_back(make_request(l2_pkg::L2_STORE, i * 3, 32'hcafe_0000 + i));
		for (int i = 0; i < 8; i++)
			todo0.push_back(make_request(l2_pkg::L2_LOAD, i * 3, '0));
		todo0.push_back(make_request(l2_pkg::L2_LOAD, 41, '0));
		wait_idle();

		// Both cores valid for many cycles
		for (int i = 0; i < 20; i++)
		begin
			todo0.push_back(make_request(l2_pkg::L2_STORE, 24 + i, 32'h5a00_0000 | i));
			todo1.push_back(make_request(l2_pkg::L2_LOAD, 24 + i, '0));
		end
		wait_idle();

		// Back-to-back burst from both cores
		for (int i = 0; i < 10; i++)
		begin
			todo0.push_back(make_request(l2_pkg::L2_STORE, 44 + i, 32'h0b00_0000 + i));
			todo1.push_back(make_request(l2_pkg::L2_STORE, 54 + i, 32'h0b10_0000 + i));
		end
		wait_idle();

		for (int i = 0; i < 4; i++)
			todo1.push_back(make_request(l2_pkg::L2_PC_READ, i, '0));
		wait_idle();

		queue_random(40);
		wait_idle();

		for (int i = 0; i < 4; i++)
			todo0.push_back(make_request(l2_pkg::L2_PC_READ, i, '0));
		wait_idle();

		// All four halt combinations
		for (int i = 0; i < 4; i++)
		begin
			@(posedge clk);
			#1;
			halt0 = i[0];
			halt1 = i[1];
			@(negedge clk);
			check_value("processor_halt", processor_halt, i[0] && i[1]);
		end

		check_value("accepted requests", accept_count, TOTAL_REQUESTS);
		check_value("responses", response_count, TOTAL_REQUESTS);
		$display("Done: %0d checks, %0d value errors, %0d other errors", check_count,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- sim/gpgpu_mem_assert.sv
// Concurrent checks on arbiter grants, queue push and pop, and response state after reset
module gpgpu_mem_assert(
	input clk,
	input reset,
	input core0_ready,
	input core1_ready,
	input push,
	input queue_full,
	input pop,
	input not_empty,
	input l2_pkg::l2rsp_packet_t l2rsp_packet);

	timeunit 1ns;
	timeprecision 100ps;

	// One grant per cycle
	one_grant: assert property (@(posedge clk) disable iff (reset) !(core0_ready && core1_ready))
		else $error("Both core readys are high in the same cycle");

	no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && queue_full))
		else $error("Request queue pushed while full");

	no_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && !not_empty))
		else $error("Request queue popped while empty");

	// Nothing left over from before reset
	rsp_idle: assert property (@(posedge clk) reset |=> !l2rsp_packet.valid)
		else $error("Response valid high in the cycle after reset");

endmodule

//--- verilog/gpgpu_mem.sv
// Memory side of a two-core GPGPU: arbiter, request queue, L2 stand-in and counters
module gpgpu_mem(
	input clk,
	input reset,
	input l2_pkg::l2req_packet_t core0_req,
	input l2_pkg::l2req_packet_t core1_req,
	output logic core0_ready,
	output logic core1_ready,
	output l2_pkg::l2rsp_packet_t l2rsp_packet,
	input halt0,
	input halt1,
	output logic processor_halt);

	logic push;
	l2_pkg::l2req_packet_t push_packet;
	logic queue_full;
	logic pop;
	l2_pkg::l2req_packet_t head;
	logic not_empty;
	pc_pkg::pc_index_t pc_select;
	logic [31:0] pc_value;
	pc_pkg::pc_events_t issue_events;
	pc_pkg::pc_events_t mem_events;
	pc_pkg::pc_events_t pc_events;

	// Whole processor halts once both cores have
	assign processor_halt = halt0 && halt1;

	core_arbiter core_arbiter(
		.clk(clk),
		.reset(reset),
		.core0_req(core0_req),
		.core1_req(core1_req),
		.core0_ready(core0_ready),
		.core1_ready(core1_ready),
		.queue_full(queue_full),
		.push(push),
		.push_packet(push_packet),
		.issue_events(issue_events));

	l2_request_queue l2_request_queue(
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_packet(push_packet),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.full(queue_full));

	l2_memory l2_memory(
		.clk(clk),
		.reset(reset),
		.head(head),
		.not_empty(not_empty),
		.pop(pop),
		.pc_select(pc_select),
		.pc_value(pc_value),
		.mem_events(mem_events),
		.l2rsp_packet(l2rsp_packet));

	// Issue bits from arbiter, access bits from memory
	assign pc_events = '{
		core0_issue: issue_events.core0_issue,
		core1_issue: issue_events.core1_issue,
		load: mem_events.load,
		store: mem_events.store
	};

	performance_counters performance_counters(
		.clk(clk),
		.reset(reset),
		.events(pc_events),
		.pc_select(pc_select),
		.pc_value(pc_value));

endmodule

//--- verilog/performance_counters.sv
// Bank of 32-bit event counters with a combinational indexed read
`include "gpgpu_macros.svh"

module performance_counters(
	input clk,
	input reset,
	input pc_pkg::pc_events_t events,
	input pc_pkg::pc_index_t pc_select,
	output logic [31:0] pc_value);

	logic [`NUM_COUNTERS - 1:0] event_bits;
	logic [31:0] counts[`NUM_COUNTERS];

	// Counter order follows pc_index_t numbering
	assign event_bits[0] = events.core0_issue;
	assign event_bits[1] = events.core1_issue;
	assign event_bits[2] = events.load;
	assign event_bits[3] = events.store;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `NUM_COUNTERS; i++)
			begin
				if (event_bits[i])
					counts[i] <= counts[i] + 32'd1;	// Wraps silently
			end
		end
	end

	assign pc_value = counts[pc_select];	// Value before this cycle's events

endmodule

//--- verilog/l2_memory.sv
// L2 stand-in that services loads, stores and counter reads from the request queue
`include "gpgpu_macros.svh"

module l2_memory(
	input clk,
	input reset,
	input l2_pkg::l2req_packet_t head,
	input not_empty,
	output logic pop,
	output pc_pkg::pc_index_t pc_select,
	input [31:0] pc_value,
	output pc_pkg::pc_events_t mem_events,
	output l2_pkg::l2rsp_packet_t l2rsp_packet);

	localparam MEM_WORDS = 1 << `MEM_ADDR_BITS;

	logic [31:0] words[MEM_WORDS];
	logic [`MEM_ADDR_BITS - 1:0] word_index;
	logic is_load;
	logic is_store;
	logic [31:0] rsp_data;
	logic rsp_valid;
	logic rsp_core;
	l2_pkg::l2_op_t rsp_op;
	logic [31:0] rsp_data_q;

	assign pop = not_empty;	// One request per cycle, no stalls
	assign word_index = head.address.mem.index;
	assign pc_select = head.address.pc.index;	// Counter view of address
	assign is_load = pop && head.op == l2_pkg::L2_LOAD;
	assign is_store = pop && head.op == l2_pkg::L2_STORE;

	// Response word by op
	always_comb
	begin
		case (head.op)
			l2_pkg::L2_STORE: rsp_data = head.data;	// Echo written word
			l2_pkg::L2_PC_READ: rsp_data = pc_value;
			default: rsp_data = words[word_index];
		endcase
	end

	always_comb
	begin
		mem_events = '0;
		mem_events.load = is_load;
		mem_events.store = is_store;
	end

	// Word memory starts out zero
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rsp_valid <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++)
				words[i] <= '0;
		end
		else
		begin
			rsp_valid <= pop;
			if (is_store)
				words[word_index] <= head.data;
		end
	end

	// Response payload, one cycle after pop
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			rsp_core <= head.core;
			rsp_op <= head.op;
			rsp_data_q <= rsp_data;
		end
	end

	assign l2rsp_packet = '{valid: rsp_valid, core: rsp_core, op: rsp_op, data: rsp_data_q};

endmodule

//--- verilog/l2_request_queue.sv
// Circular FIFO of stamped L2 requests between the arbiter and the memory
`include "gpgpu_macros.svh"

module l2_request_queue(
	input clk,
	input reset,
	input push,
	input l2_pkg::l2req_packet_t push_packet,
	input pop,
	output l2_pkg::l2req_packet_t head,
	output logic not_empty,
	output logic full);

	localparam DEPTH = 1 << `QUEUE_DEPTH_BITS;

	l2_pkg::l2req_packet_t entries[DEPTH];
	logic [`QUEUE_DEPTH_BITS - 1:0] wr_ptr;
	logic [`QUEUE_DEPTH_BITS - 1:0] rd_ptr;
	logic [`QUEUE_DEPTH_BITS:0] count;	// One extra bit so full fits

	// Pointers wrap on their own
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;

			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			// Push and pop together leave count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= push_packet;
	end

	assign head = entries[rd_ptr];	// Meaningless while empty
	assign not_empty = count != '0;
	assign full = count == (`QUEUE_DEPTH_BITS + 1)'(DEPTH);

endmodule

//--- verilog/core_arbiter.sv
// Round-robin arbiter between two core request ports, stamps core number on winner
module core_arbiter(
	input clk,
	input reset,
	input l2_pkg::l2req_packet_t core0_req,
	input l2_pkg::l2req_packet_t core1_req,
	output logic core0_ready,
	output logic core1_ready,
	input queue_full,
	output logic push,
	output l2_pkg::l2req_packet_t push_packet,
	output pc_pkg::pc_events_t issue_events);

	logic last_grant;	// Core accepted most recently
	logic pick_core0;
	l2_pkg::l2req_packet_t winner;

	// Alternate when both are asking
	always_comb
	begin
		if (core0_req.valid && core1_req.valid)
			pick_core0 = last_grant;	// Core 1 went last, core 0 now
		else
			pick_core0 = core0_req.valid;
	end

	// Full queue holds both cores off
	assign core0_ready = pick_core0 && !queue_full;
	assign core1_ready = !pick_core0 && core1_req.valid && !queue_full;
	assign push = core0_ready || core1_ready;

	always_comb
	begin
		winner = pick_core0 ? core0_req : core1_req;
		winner.core = !pick_core0;	// Overwrite core field
	end

	assign push_packet = winner;

	// Only issue bits come from here
	always_comb
	begin
		issue_events = '0;
		issue_events.core0_issue = core0_ready;
		issue_events.core1_issue = core1_ready;
	end

	// Moves only on an acceptance
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= 1'b1;	// As if core 1 just won
		else if (push)
			last_grant <= core1_ready;
	end

endmodule

//--- verilog/l2_pkg.sv
// Request and response packet types of the L2 request protocol
`include "gpgpu_macros.svh"

package l2_pkg;

	typedef enum logic [1:0]
	{
		L2_LOAD = 2'd0,
		L2_STORE = 2'd1,
		L2_PC_READ = 2'd2
	} l2_op_t;

	// Address word as seen by loads and stores
	typedef struct packed
	{
		logic [31 - `MEM_ADDR_BITS:0] unused;
		logic [`MEM_ADDR_BITS - 1:0] index;	// Word index into memory
	} l2_mem_addr_t;

	// Address word as seen by counter reads
	typedef struct packed
	{
		logic [31 - $bits(pc_pkg::pc_index_t):0] unused;
		pc_pkg::pc_index_t index;	// Counter number
	} l2_pc_addr_t;

	// Same 32 bits, meaning picked by op
	typedef union packed
	{
		l2_mem_addr_t mem;
		l2_pc_addr_t pc;
	} l2_addr_u;

	typedef struct packed
	{
		logic valid;
		logic core;	// Stamped by arbiter, cores send 0
		l2_op_t op;
		l2_addr_u address;
		logic [31:0] data;	// Store data
	} l2req_packet_t;

	typedef struct packed
	{
		logic valid;
		logic core;	// Requesting core
		l2_op_t op;
		logic [31:0] data;	// Load word, store echo or count
	} l2rsp_packet_t;

endpackage

//--- verilog/pc_pkg.sv
// Performance-counter event bundle and counter index types
`include "gpgpu_macros.svh"

package pc_pkg;

	// Counter number
	// 0 core 0 issues, 1 core 1 issues, 2 loads, 3 stores
	typedef logic [$clog2(`NUM_COUNTERS) - 1:0] pc_index_t;

	// One-cycle event strobes, one per counter
	typedef struct packed
	{
		logic core0_issue;	// Core 0 request accepted
		logic core1_issue;	// Core 1 request accepted
		logic load;	// Load serviced
		logic store;	// Store serviced
	} pc_events_t;

endpackage

//--- verilog/gpgpu_macros.svh
// Sizing constants shared by the GPGPU memory-side blocks
`ifndef GPGPU_MACROS_SVH
`define GPGPU_MACROS_SVH

// Word address width of the L2 stand-in, 64 words
`define MEM_ADDR_BITS 6

// Log2 of request queue depth, 4 entries
`define QUEUE_DEPTH_BITS 2

// Event counters in the performance counter block
`define NUM_COUNTERS 4

`endif
